//--- common/systolic_pkg.sv
`default_nettype none

package systolic_pkg;

    // mesh is ARRAY_N by ARRAY_N cells
    localparam int ARRAY_N = 4;

    // one matrix word, also used as the accumulator
    // products and sums wrap at 32 bits
    typedef logic signed [31:0] elem_t;

    // one operand column, operand row or result row
    // lane 0 sits in the low word
    typedef struct packed {
        elem_t [ARRAY_N-1:0] lane;
    } vec_t;

    // full accumulator matrix, entry [i] is row i of C
    typedef vec_t [ARRAY_N-1:0] grid_t;

endpackage

`default_nettype wire

//--- common/sched_pkg.sv
`default_nettype none

package sched_pkg;

    // controller phases
    typedef enum logic [1:0] {
        IDLE,
        FEED,
        DRAIN,
        UNLOAD
    } state_t;

    // operand pairs enter over N cycles
    localparam int FEED_LEN = systolic_pkg::ARRAY_N;

    // last operand still needs 2N-1 cycles to reach the far corner cell
    localparam int DRAIN_LEN = 2 * systolic_pkg::ARRAY_N - 1;

    // one result row per cycle
    localparam int UNLOAD_LEN = systolic_pkg::ARRAY_N;

    // cycle count inside a phase, sized for DRAIN_LEN-1
    typedef logic [2:0] phase_cnt_t;

endpackage

`default_nettype wire

//--- verilog/array_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module array_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              phase_last,
    output sched_pkg::state_t state,
    output logic              busy,
    output logic              clear,
    output logic              compute
);

    sched_pkg::state_t state_next;

    // each phase ends when the counter flags its last cycle
    always_comb begin
        state_next = state;
        case (state)
            sched_pkg::IDLE: begin
                if (start) begin
                    state_next = sched_pkg::FEED;
                end
            end
            sched_pkg::FEED: begin
                if (phase_last) begin
                    state_next = sched_pkg::DRAIN;
                end
            end
            sched_pkg::DRAIN: begin
                if (phase_last) begin
                    state_next = sched_pkg::UNLOAD;
                end
            end
            sched_pkg::UNLOAD: begin
                if (phase_last) begin
                    state_next = sched_pkg::IDLE;
                end
            end
            default: begin
                state_next = sched_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= sched_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign busy = (state != sched_pkg::IDLE);

    // accumulators zero on the accepting edge
    assign clear = (state == sched_pkg::IDLE) && start;

    // mesh runs until the last product lands in the corner cell
    assign compute = (state == sched_pkg::FEED) || (state == sched_pkg::DRAIN);

endmodule

`default_nettype wire

//--- verilog/phase_counter.sv
`timescale 1ns/1ns
`default_nettype none

module phase_counter (
    input  logic              clk,
    input  logic              reset,
    input  sched_pkg::state_t state,
    output logic              phase_last
);

    sched_pkg::state_t    state_q;
    sched_pkg::phase_cnt_t count;
    sched_pkg::phase_cnt_t count_cur;
    sched_pkg::phase_cnt_t last_count;

    // first cycle of a new state reads as zero
    assign count_cur = (state != state_q) ? '0 : count;

    always_comb begin
        case (state)
            sched_pkg::FEED:   last_count = sched_pkg::phase_cnt_t'(sched_pkg::FEED_LEN - 1);
            sched_pkg::DRAIN:  last_count = sched_pkg::phase_cnt_t'(sched_pkg::DRAIN_LEN - 1);
            sched_pkg::UNLOAD: last_count = sched_pkg::phase_cnt_t'(sched_pkg::UNLOAD_LEN - 1);
            default:           last_count = '0;
        endcase
    end

    // idle has no length, it waits for start
    assign phase_last = (state != sched_pkg::IDLE) && (count_cur == last_count);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state_q <= sched_pkg::IDLE;
            count   <= '0;
        end else begin
            state_q <= state;
            if (state == sched_pkg::IDLE) begin
                count <= '0;
            end else begin
                count <= count_cur + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- pe_array/skew_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module skew_buffer (
    input  logic               clk,
    input  logic               reset,
    input  logic               feed,
    input  systolic_pkg::vec_t lanes_in,
    output systolic_pkg::vec_t lanes_out
);

    systolic_pkg::vec_t  sample_q;
    systolic_pkg::vec_t  gated;
    systolic_pkg::elem_t delayed [systolic_pkg::ARRAY_N];

    // boundary register, caller data is taken on every edge
    always_ff @(posedge clk) begin
        sample_q <= lanes_in;
    end

    // zeros fill the slots before and after the operand burst
    assign gated = feed ? sample_q : '0;

    assign delayed[0] = gated.lane[0];

    // triangular delay lines, lane k is k stages deep
    for (genvar k = 1; k < systolic_pkg::ARRAY_N; k++) begin : g_lane
        systolic_pkg::elem_t line_q [k];

        always_ff @(posedge clk) begin
            if (!reset) begin
                for (int s = 0; s < k; s++) begin
                    line_q[s] <= '0;
                end
            end else begin
                line_q[0] <= gated.lane[k];
                for (int s = 1; s < k; s++) begin
                    line_q[s] <= line_q[s-1];
                end
            end
        end

        assign delayed[k] = line_q[k-1];
    end

    always_comb begin
        for (int k = 0; k < systolic_pkg::ARRAY_N; k++) begin
            lanes_out.lane[k] = delayed[k];
        end
    end

endmodule

`default_nettype wire

//--- pe_array/pe.sv
`timescale 1ns/1ns
`default_nettype none

module pe (
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    input  logic                compute,
    input  systolic_pkg::elem_t a_in,
    input  systolic_pkg::elem_t b_in,
    output systolic_pkg::elem_t a_out,
    output systolic_pkg::elem_t b_out,
    output systolic_pkg::elem_t acc
);

    systolic_pkg::elem_t product;

    // low 32 bits only, the sum wraps the same way
    assign product = a_out * b_out;

    // operand hop registers, also the multiplier inputs
    always_ff @(posedge clk) begin
        if (!reset) begin
            a_out <= '0;
            b_out <= '0;
        end else if (compute) begin
            a_out <= a_in;
            b_out <= b_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (compute) begin
            acc <= acc + product;
        end
    end

endmodule

`default_nettype wire

//--- pe_array/pe_grid.sv
`timescale 1ns/1ns
`default_nettype none

module pe_grid (
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    input  logic                compute,
    input  systolic_pkg::vec_t  row_in,
    input  systolic_pkg::vec_t  col_in,
    output systolic_pkg::grid_t acc
);

    // a moves east along a row, b moves south along a column
    // the extra column and row catch the outputs of the far edge
    systolic_pkg::elem_t a_link   [systolic_pkg::ARRAY_N][systolic_pkg::ARRAY_N+1];
    systolic_pkg::elem_t b_link   [systolic_pkg::ARRAY_N+1][systolic_pkg::ARRAY_N];
    systolic_pkg::elem_t acc_cell [systolic_pkg::ARRAY_N][systolic_pkg::ARRAY_N];

    for (genvar i = 0; i < systolic_pkg::ARRAY_N; i++) begin : g_west
        assign a_link[i][0] = row_in.lane[i];
    end

    for (genvar j = 0; j < systolic_pkg::ARRAY_N; j++) begin : g_north
        assign b_link[0][j] = col_in.lane[j];
    end

    for (genvar i = 0; i < systolic_pkg::ARRAY_N; i++) begin : g_row
        for (genvar j = 0; j < systolic_pkg::ARRAY_N; j++) begin : g_col
            pe u_pe (
                .clk     (clk),
                .reset   (reset),
                .clear   (clear),
                .compute (compute),
                .a_in    (a_link[i][j]),
                .b_in    (b_link[i][j]),
                .a_out   (a_link[i][j+1]),
                .b_out   (b_link[i+1][j]),
                .acc     (acc_cell[i][j])
            );
        end
    end

    // cell (i,j) is C[i][j]
    always_comb begin
        for (int i = 0; i < systolic_pkg::ARRAY_N; i++) begin
            for (int j = 0; j < systolic_pkg::ARRAY_N; j++) begin
                acc[i].lane[j] = acc_cell[i][j];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/result_unload.sv
`timescale 1ns/1ns
`default_nettype none

module result_unload (
    input  logic                clk,
    input  logic                reset,
    input  sched_pkg::state_t   state,
    input  systolic_pkg::grid_t acc,
    output systolic_pkg::vec_t  result,
    output logic                result_valid
);

    logic [$clog2(systolic_pkg::ARRAY_N)-1:0] row_idx;

    // row 0 on the first unload cycle, then one row per cycle
    always_ff @(posedge clk) begin
        if (!reset) begin
            row_idx <= '0;
        end else if (state == sched_pkg::UNLOAD) begin
            row_idx <= row_idx + 1'b1;
        end else begin
            row_idx <= '0;
        end
    end

    // accumulators are final and held still for the whole unload phase
    assign result_valid = (state == sched_pkg::UNLOAD);
    assign result       = result_valid ? acc[row_idx] : '0;

endmodule

`default_nettype wire

//--- verilog/matmul_top.sv
`timescale 1ns/1ns
`default_nettype none

module matmul_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  systolic_pkg::vec_t a_col,
    input  systolic_pkg::vec_t b_row,
    output logic               busy,
    output logic               result_valid,
    output systolic_pkg::vec_t result
);

    sched_pkg::state_t   state;
    logic                phase_last;
    logic                clear;
    logic                compute;
    systolic_pkg::vec_t  row_in;
    systolic_pkg::vec_t  col_in;
    systolic_pkg::grid_t acc;

    array_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .phase_last (phase_last),
        .state      (state),
        .busy       (busy),
        .clear      (clear),
        .compute    (compute)
    );

    phase_counter u_phase (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .phase_last (phase_last)
    );

    // A columns enter the rows from the west
    skew_buffer u_skew_a (
        .clk       (clk),
        .reset     (reset),
        .feed      (state == sched_pkg::FEED),
        .lanes_in  (a_col),
        .lanes_out (row_in)
    );

    // B rows enter the columns from the north
    skew_buffer u_skew_b (
        .clk       (clk),
        .reset     (reset),
        .feed      (state == sched_pkg::FEED),
        .lanes_in  (b_row),
        .lanes_out (col_in)
    );

    pe_grid u_grid (
        .clk     (clk),
        .reset   (reset),
        .clear   (clear),
        .compute (compute),
        .row_in  (row_in),
        .col_in  (col_in),
        .acc     (acc)
    );

    result_unload u_unload (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .acc          (acc),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

//--- dv/matmul_tb_assert.sv
`timescale 1ns/1ns
`default_nettype none

module matmul_tb_assert (
    input logic clk,
    input logic reset,
    input logic start,
    input logic busy,
    input logic result_valid
);

    // rows only come out while a multiply is running
    valid_needs_busy: assert property (@(posedge clk) disable iff (!reset)
        result_valid |-> busy)
        else $error("result_valid high while busy is low");

    // one row per cycle, exactly ARRAY_N rows
    valid_length: assert property (@(posedge clk) disable iff (!reset)
        $rose(result_valid) |-> result_valid [*systolic_pkg::ARRAY_N] ##1 !result_valid)
        else $error("result_valid did not stay high for exactly one row per lane");

    busy_after_start: assert property (@(posedge clk) disable iff (!reset)
        $rose(busy) |-> $past(start))
        else $error("busy rose without a start on the previous edge");

endmodule

bind matmul_top matmul_tb_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .busy         (busy),
    .result_valid (result_valid)
);

`default_nettype wire

//--- dv/matmul_tb.sv
`timescale 1ns/1ns
`default_nettype none

module matmul_tb;

    // one multiply from start to the idle cycle after unload plus slack
    localparam int MULT_LEN = sched_pkg::FEED_LEN + sched_pkg::DRAIN_LEN
                              + sched_pkg::UNLOAD_LEN + 2;
    localparam int MULT_COUNT = 6;
    localparam int TIMEOUT_CYCLES = 20 * MULT_COUNT * MULT_LEN;
    localparam int N = systolic_pkg::ARRAY_N;

    logic               clk;
    logic               reset;
    logic               start;
    systolic_pkg::vec_t a_col;
    systolic_pkg::vec_t b_row;
    logic               busy;
    logic               result_valid;
    systolic_pkg::vec_t result;

    int    error_count;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    int    cycle_count;
    string test_name;

    matmul_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .a_col        (a_col),
        .b_row        (b_row),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not complete", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // C[i][j] is the sum over k of A[i][k] * B[k][j] wrapped to 32 bits
    function automatic systolic_pkg::grid_t ref_product(input systolic_pkg::grid_t a,
                                                        input systolic_pkg::grid_t b);
        systolic_pkg::grid_t c;
        systolic_pkg::elem_t sum;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                sum = '0;
                for (int k = 0; k < N; k++) begin
                    sum = sum + a[i].lane[k] * b[k].lane[j];
                end
                c[i].lane[j] = sum;
            end
        end
        return c;
    endfunction

    function automatic systolic_pkg::grid_t random_matrix();
        systolic_pkg::grid_t m;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                m[i].lane[j] = $urandom;
            end
        end
        return m;
    endfunction

    task automatic check_vec(input string what, input systolic_pkg::vec_t expected,
                             input systolic_pkg::vec_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, error_count - test_errors);
        end
    endtask

    // k=0 pair goes out with start and k=1..3 on the following edges
    task automatic feed_operands(input systolic_pkg::grid_t a, input systolic_pkg::grid_t b);
        systolic_pkg::vec_t col;
        for (int k = 0; k < N; k++) begin
            for (int i = 0; i < N; i++) begin
                col.lane[i] = a[i].lane[k];
            end
            @(posedge clk);
            start <= (k == 0);
            a_col <= col;
            b_row <= b[k];
        end
        @(posedge clk);
        start <= 1'b0;
        a_col <= '0;
        b_row <= '0;
    endtask

    // waits for the first valid row, then expects four rows back to back
    task automatic collect_rows(input systolic_pkg::grid_t expected);
        int wait_cycles;
        wait_cycles = 0;
        @(negedge clk);
        while (!result_valid) begin
            if (!busy || wait_cycles == 2 * MULT_LEN) begin
                error_count++;
                $display("%s: no result rows arrived while the DUT was busy", test_name);
                return;
            end
            @(negedge clk);
            wait_cycles++;
        end
        for (int r = 0; r < N; r++) begin
            // row 0 was found by its valid flag
            if (r > 0) begin
                check_bit($sformatf("result_valid row %0d", r), 1'b1, result_valid);
            end
            check_bit($sformatf("busy row %0d", r), 1'b1, busy);
            check_vec($sformatf("row %0d", r), expected[r], result);
            @(negedge clk);
        end
        check_bit("result_valid after unload", 1'b0, result_valid);
        check_bit("busy after unload", 1'b0, busy);
        check_vec("result after unload", '0, result);
    endtask

    task automatic identity_times_b();
        systolic_pkg::grid_t ident;
        systolic_pkg::grid_t b;
        begin_test("identity_times_b");
        ident = '0;
        for (int i = 0; i < N; i++) begin
            ident[i].lane[i] = 32'sd1;
        end
        b = random_matrix();
        feed_operands(ident, b);
        // rows of C are the rows of B
        collect_rows(b);
        end_test();
    endtask

    task automatic random_large_values();
        systolic_pkg::grid_t a;
        systolic_pkg::grid_t b;
        begin_test("random_large_values");
        a = random_matrix();
        b = random_matrix();
        a[0].lane[0] = 32'sh7fffffff;
        b[0].lane[0] = 32'sh80000000;
        a[3].lane[3] = 32'sh80000000;
        b[3].lane[3] = 32'sh80000000;
        feed_operands(a, b);
        collect_rows(ref_product(a, b));
        end_test();
    endtask

    task automatic back_to_back();
        systolic_pkg::grid_t a;
        systolic_pkg::grid_t b;
        begin_test("back_to_back");
        a = random_matrix();
        b = random_matrix();
        feed_operands(a, b);
        collect_rows(ref_product(a, b));
        // second product carries nothing over from the first
        a = random_matrix();
        b = random_matrix();
        feed_operands(a, b);
        collect_rows(ref_product(a, b));
        end_test();
    endtask

    task automatic start_while_busy();
        systolic_pkg::grid_t a;
        systolic_pkg::grid_t b;
        begin_test("start_while_busy");
        a = random_matrix();
        b = random_matrix();
        feed_operands(a, b);
        // start lands in the drain phase
        repeat (2) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        collect_rows(ref_product(a, b));
        repeat (MULT_LEN) begin
            @(negedge clk);
            check_bit("busy after ignored start", 1'b0, busy);
        end
        end_test();
    endtask

    task automatic reset_mid_drain();
        systolic_pkg::grid_t a;
        systolic_pkg::grid_t b;
        begin_test("reset_mid_drain");
        a = random_matrix();
        b = random_matrix();
        feed_operands(a, b);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit("busy in reset", 1'b0, busy);
        check_bit("result_valid in reset", 1'b0, result_valid);
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_bit("busy after reset", 1'b0, busy);
        check_bit("result_valid after reset", 1'b0, result_valid);
        a = random_matrix();
        b = random_matrix();
        feed_operands(a, b);
        collect_rows(ref_product(a, b));
        end_test();
    endtask

    initial begin
        reset = 1'b0;
        start = 1'b0;
        a_col = '0;
        b_row = '0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        test_name = "reset";
        void'($urandom(32'he08e));
        repeat (10) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_bit("busy", 1'b0, busy);
        check_bit("result_valid", 1'b0, result_valid);
        identity_times_b();
        random_large_values();
        back_to_back();
        start_while_busy();
        reset_mid_drain();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
common/systolic_pkg.sv
common/sched_pkg.sv
verilog/array_ctrl.sv
verilog/phase_counter.sv
pe_array/skew_buffer.sv
pe_array/pe.sv
pe_array/pe_grid.sv
verilog/result_unload.sv
verilog/matmul_top.sv
dv/matmul_tb_assert.sv
dv/matmul_tb.sv
